//--- verilog.f
+incdir+src
src/core_pkg.sv
src/core_fetch.sv
src/core_decode.sv
src/core_reg_bank.sv
src/core_execute.sv
src/core_top.sv
test/tb_clock.sv
test/tb_core.sv

//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core

obj_dir/Vtb_core: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core -f verilog.f

clean:
	rm -rf obj_dir

//--- test/tb_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core import core_pkg::*; ();

   logic       clk_i, rst_ni;
   logic       restart_i, en_i, flag_i;
   pmem_addr_t pmem_addr;
   logic       pmem_en;
   instr_t     pmem_dt = '0;
   logic       dmem_we;
   dmem_addr_t dmem_addr;
   data_t      dmem_w_dt;
   data_t      dmem_r_dt = '0;

   instr_t     pmem [256];
   data_t      dmem [256];
   data_t      mdmem [256];    // Reference copy of the data memory
   dmem_addr_t exp_addr [$];
   data_t      exp_data [$];
   int         wr_idx = 0;
   int         budget = 0;     // Cycles left before the watchdog fires
   int         pc_b = 0;
   logic [31:0] lfsr = 32'h9e82c8e7;

   tb_clock u_clock (.clk_o(clk_i), .rst_no(rst_ni));

   core_top uut (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .restart_i   (restart_i),
      .en_i        (en_i),
      .flag_i      (flag_i),
      .pmem_addr_o (pmem_addr),
      .pmem_en_o   (pmem_en),
      .pmem_dt_i   (pmem_dt),
      .dmem_we_o   (dmem_we),
      .dmem_addr_o (dmem_addr),
      .dmem_w_dt_o (dmem_w_dt),
      .dmem_r_dt_i (dmem_r_dt)
   );

   //////////////////////////////////////////////////////////////////////
   // Memory models, one cycle read

   always @(posedge clk_i) begin
      if (pmem_en) pmem_dt <= pmem[pmem_addr];
      dmem_r_dt <= dmem[dmem_addr];
      if (dmem_we) dmem[dmem_addr] <= dmem_w_dt;
   end

   task automatic abort(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // Store monitor, compares against the reference list in order
   always @(posedge clk_i) begin
      if (rst_ni && !en_i) begin
         check("pmem_en_o", 32'(pmem_en), 32'd0);   // No fetch while halted
      end
      if (rst_ni && dmem_we) begin
         if (!en_i) begin
            abort("A store appeared while the core was halted");
         end else if (wr_idx >= exp_addr.size()) begin
            abort($sformatf("Unexpected store to address 0x%h", dmem_addr));
         end else begin
            check("dmem_addr_o", 32'(dmem_addr), 32'(exp_addr[wr_idx]));
            check("dmem_w_dt_o", dmem_w_dt, exp_data[wr_idx]);
            wr_idx++;
         end
      end
   end

   always @(posedge clk_i) begin
      if (budget > 0) begin
         budget--;
         if (budget == 0) abort("Timeout waiting for the expected stores");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // LFSR and program builder

   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [15:0] rand_imm();
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < 16; i++) r = {r[14:0], next_bit()};
      return r;
   endfunction

   task automatic emit(input logic [2:0] hdr, input logic [2:0] cond, input logic [2:0] op,
                       input logic isel, input logic fw, input logic [3:0] rd,
                       input logic [3:0] rs0, input logic [3:0] rs1, input logic [15:0] imm);
      pmem[pc_b] = {hdr, cond, op, isel, fw, 1'b0, rd, rs0, rs1, imm};
      pc_b++;
   endtask

   task automatic store_at(input logic [2:0] cond, input logic [3:0] rs0,
                           input logic [3:0] rs1, input logic [15:0] imm);
      emit(HDR_MEM_WR, cond, ALU_ADD, 1'b0, 1'b0, 4'd0, rs0, rs1, imm);
   endtask

   task automatic load_from(input logic [3:0] rd, input logic [3:0] rs0, input logic [15:0] imm);
      emit(HDR_REG_LD, COND_ALWAYS, ALU_ADD, 1'b0, 1'b0, rd, rs0, 4'd0, imm);
   endtask

   task automatic branch_to(input logic [2:0] cond, input int target);
      emit(HDR_BRANCH, cond, ALU_ADD, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 16'(target));
   endtask

   task automatic end_loop();
      branch_to(COND_ALWAYS, pc_b);   // Spin on itself
   endtask

   // Halt the core first so that it never fetches a half-written program
   task automatic new_program();
      @(posedge clk_i);
      en_i <= 1'b0;
      @(posedge clk_i);
      for (int i = 0; i < 256; i++) pmem[i] = '0;
      pc_b = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model of the instruction set

   function automatic data_t alu_model(input logic [2:0] op, input data_t a, input data_t b);
      case (op)
         3'd0: return a + b;
         3'd1: return a - b;
         3'd2: return a & b;
         3'd3: return a | b;
         3'd4: return a ^ b;
         3'd5: return a << b[4:0];
         3'd6: return a >> b[4:0];
         default: return b;
      endcase
   endfunction

   task automatic predict();
      data_t      r [16];
      logic       z, s, ok, stop;
      logic [7:0] pc;
      instr_t     w;
      data_t      imm, a, b, res, sum;
      int         steps;
      for (int i = 0; i < 16; i++) r[i] = '0;
      exp_addr.delete();
      exp_data.delete();
      wr_idx = 0;
      z = 1'b0;
      s = 1'b0;
      pc = '0;
      stop = 1'b0;
      steps = 0;
      while (!stop) begin
         w   = pmem[pc];
         imm = {{16{w[15]}}, w[15:0]};
         case (w[36:34])
            3'd0: ok = 1'b1;
            3'd1: ok = z;
            3'd2: ok = s;
            3'd3: ok = !z;
            3'd4: ok = !s;
            3'd5: ok = flag_i;
            3'd6: ok = !flag_i;
            default: ok = 1'b0;
         endcase
         a   = r[w[23:20]];
         b   = w[30] ? imm : r[w[19:16]];
         sum = a + imm;
         pc  = pc + 8'd1;
         if (ok) begin
            case (w[39:37])
               3'd1: begin
                  res = alu_model(w[33:31], a, b);
                  r[w[27:24]] = res;
                  if (w[29]) begin
                     z = (res == '0);
                     s = res[31];
                  end
               end
               3'd2: r[w[27:24]] = mdmem[sum[7:0]];
               3'd3: begin
                  mdmem[sum[7:0]] = r[w[19:16]];
                  exp_addr.push_back(sum[7:0]);
                  exp_data.push_back(r[w[19:16]]);
               end
               3'd4: begin
                  if (w[7:0] == pc - 8'd1) stop = 1'b1;
                  pc = w[7:0];
               end
               default: ;
            endcase
         end
         r[0] = '0;
         steps++;
         if (steps > 2000) abort("Reference model never reached the end loop");
      end
   endtask

   // Restart the core on the loaded program and wait for every store
   task automatic run(input int halt_at);
      int cyc;
      predict();
      @(posedge clk_i);
      en_i      <= 1'b0;
      restart_i <= 1'b1;
      @(posedge clk_i);
      restart_i <= 1'b0;
      en_i      <= 1'b1;
      budget = 200 * pc_b;
      cyc = 0;
      while (wr_idx < exp_addr.size()) begin
         @(posedge clk_i);
         cyc++;
         if (halt_at > 0 && cyc == halt_at) en_i <= 1'b0;
         if (halt_at > 0 && cyc == halt_at + 8) en_i <= 1'b1;
      end
      en_i <= 1'b1;
      repeat (20) @(posedge clk_i);   // Catch stray stores
      budget = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic reset_state();
      repeat (4) @(posedge clk_i);
      check("dmem_we_o", 32'(dmem_we), 32'd0);
      check("pmem_addr_o", 32'(pmem_addr), 32'd0);
      wait (rst_ni);
      @(posedge clk_i);
      check("dmem_we_o", 32'(dmem_we), 32'd0);
      check("pmem_addr_o", 32'(pmem_addr), 32'd0);
   endtask

   task automatic alu_ops();
      new_program();
      for (int i = 0; i < 8; i++) begin
         emit(HDR_REG_WR, COND_ALWAYS, ALU_ADD, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, rand_imm());
         emit(HDR_REG_WR, COND_ALWAYS, 3'(i), 1'b1, 1'b1, 4'd2, 4'd1, 4'd0, rand_imm());
         emit(HDR_REG_WR, COND_ALWAYS, 3'(i), 1'b0, 1'b0, 4'd3, 4'd2, 4'd1, 16'd0);
         store_at(COND_ALWAYS, 4'd0, 4'd2, 16'(2 * i));
         store_at(COND_ALWAYS, 4'd0, 4'd3, 16'(2 * i + 1));
      end
      end_loop();
      run(0);
   endtask

   task automatic store_load();
      new_program();
      emit(HDR_REG_WR, COND_ALWAYS, ALU_ADD, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 16'h7abc);
      store_at(COND_ALWAYS, 4'd0, 4'd1, 16'd16);
      load_from(4'd4, 4'd0, 16'd16);
      store_at(COND_ALWAYS, 4'd0, 4'd4, 16'd17);   // Load-use stall
      emit(HDR_REG_WR, COND_ALWAYS, ALU_ADD, 1'b1, 1'b0, 4'd6, 4'd0, 4'd0, 16'd30);
      load_from(4'd7, 4'd6, 16'hfffe);              // Negative offset
      store_at(COND_ALWAYS, 4'd6, 4'd7, 16'd20);
      load_from(4'd8, 4'd0, 16'd200);
      emit(HDR_REG_WR, COND_ALWAYS, ALU_ADD, 1'b0, 1'b0, 4'd9, 4'd8, 4'd7, 16'd0);
      store_at(COND_ALWAYS, 4'd0, 4'd9, 16'd51);
      end_loop();
      run(0);
   endtask

   task automatic conditions();
      new_program();
      emit(HDR_REG_WR, COND_ALWAYS, ALU_ADD, 1'b1, 1'b0, 4'd1, 4'd0, 4'd0, 16'd5);
      emit(HDR_REG_WR, COND_ALWAYS, ALU_SUB, 1'b1, 1'b1, 4'd2, 4'd1, 4'd0, 16'd5);
      emit(HDR_REG_WR, COND_Z, ALU_PASS, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 16'h1111);
      emit(HDR_REG_WR, COND_NZ, ALU_PASS, 1'b1, 1'b0, 4'd3, 4'd0, 4'd0, 16'h2222);
      store_at(COND_ALWAYS, 4'd0, 4'd3, 16'h60);
      emit(HDR_REG_WR, COND_ALWAYS, ALU_SUB, 1'b1, 1'b1, 4'd4, 4'd0, 4'd0, 16'd1);
      store_at(COND_S, 4'd0, 4'd4, 16'h61);
      store_at(COND_NS, 4'd0, 4'd4, 16'h62);
      store_at(COND_Z, 4'd0, 4'd4, 16'h63);
      store_at(COND_FLAG, 4'd0, 4'd1, 16'h64);
      store_at(COND_NFLAG, 4'd0, 4'd3, 16'h65);
      store_at(COND_NEVER, 4'd0, 4'd1, 16'h66);
      branch_to(COND_S, pc_b + 3);
      store_at(COND_ALWAYS, 4'd0, 4'd1, 16'h67);   // Flushed slots
      store_at(COND_ALWAYS, 4'd0, 4'd1, 16'h68);
      branch_to(COND_Z, pc_b + 3);                 // Not taken
      store_at(COND_ALWAYS, 4'd0, 4'd4, 16'h69);
      store_at(COND_ALWAYS, 4'd0, 4'd3, 16'h6a);
      end_loop();
      flag_i <= 1'b0;
      @(posedge clk_i);
      run(0);
      flag_i <= 1'b1;
      @(posedge clk_i);
      run(0);
   endtask

   // Reruns the loaded program with the core halted for eight cycles
   task automatic halt_resume();
      run(6);
   endtask

   // Second run starts with r5 and S left set by the first one
   task automatic restart_rerun();
      new_program();
      store_at(COND_ALWAYS, 4'd0, 4'd5, 16'h70);   // r5 cleared
      store_at(COND_S, 4'd0, 4'd5, 16'h71);        // S cleared, skipped
      emit(HDR_REG_WR, COND_ALWAYS, ALU_SUB, 1'b1, 1'b1, 4'd5, 4'd0, 4'd0, 16'd1);
      store_at(COND_S, 4'd0, 4'd5, 16'h72);
      end_loop();
      run(0);
      run(0);
   endtask

   initial begin
      restart_i = 1'b0;
      en_i      = 1'b1;   // Running through reset
      flag_i    = 1'b0;
      for (int i = 0; i < 256; i++) begin
         dmem[i]  = (32'(i) * 32'h9e3779b1) ^ 32'h0f1e2d3c;   // Whole-address fill
         mdmem[i] = dmem[i];
         pmem[i]  = '0;
      end
      reset_state();
      alu_ops();
      store_load();
      conditions();
      store_load();
      halt_resume();
      restart_rerun();
      $display("Regression passed");
      $finish;
   end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;   // 10 ns period
   end

   initial begin
      rst_no = 1'b0;
      repeat (16) @(posedge clk_o);
      rst_no <= 1'b1;
   end

endmodule

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       restart_i,
   input  logic       en_i,
   input  logic       flag_i,
   output pmem_addr_t pmem_addr_o,
   output logic       pmem_en_o,
   input  instr_t     pmem_dt_i,
   output logic       dmem_we_o,
   output dmem_addr_t dmem_addr_o,
   output data_t      dmem_w_dt_o,
   input  data_t      dmem_r_dt_i
);

   // Fetch and decode
   instr_t     instr;
   logic       stall, branch;
   pmem_addr_t target;
   reg_addr_t  rs0, rs1;
   data_t      rs0_dt, rs1_dt;

   // Decode to execute
   data_t      op_a, op_b, st_dt;
   alu_op_e    alu_op;
   reg_addr_t  rd;
   logic       rd_we, load, store, flag_we;

   // Execute feedback and write-back
   reg_addr_t  x1_rd;
   logic       x1_rd_we, x1_flag_we;
   logic       flag_z, flag_s;
   logic       wb_we, wb_load;
   reg_addr_t  wb_rd;
   data_t      wb_alu_dt;

   core_fetch u_fetch (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .restart_i   (restart_i),
      .run_i       (en_i),
      .stall_i     (stall),
      .branch_i    (branch),
      .target_i    (target),
      .pmem_dt_i   (pmem_dt_i),
      .pmem_addr_o (pmem_addr_o),
      .pmem_en_o   (pmem_en_o),
      .instr_o     (instr)
   );

   core_decode u_decode (
      .instr_i      (instr),
      .rs0_dt_i     (rs0_dt),
      .rs1_dt_i     (rs1_dt),
      .x1_rd_i      (x1_rd),
      .x1_rd_we_i   (x1_rd_we),
      .x1_flag_we_i (x1_flag_we),
      .flag_z_i     (flag_z),
      .flag_s_i     (flag_s),
      .flag_i       (flag_i),
      .rs0_o        (rs0),
      .rs1_o        (rs1),
      .stall_o      (stall),
      .branch_o     (branch),
      .target_o     (target),
      .op_a_o       (op_a),
      .op_b_o       (op_b),
      .st_dt_o      (st_dt),
      .alu_op_o     (alu_op),
      .rd_o         (rd),
      .rd_we_o      (rd_we),
      .load_o       (load),
      .store_o      (store),
      .flag_we_o    (flag_we)
   );

   core_execute u_execute (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .restart_i    (restart_i),
      .run_i        (en_i),
      .op_a_i       (op_a),
      .op_b_i       (op_b),
      .st_dt_i      (st_dt),
      .alu_op_i     (alu_op),
      .rd_i         (rd),
      .rd_we_i      (rd_we),
      .load_i       (load),
      .store_i      (store),
      .flag_we_i    (flag_we),
      .x1_rd_o      (x1_rd),
      .x1_rd_we_o   (x1_rd_we),
      .x1_flag_we_o (x1_flag_we),
      .flag_z_o     (flag_z),
      .flag_s_o     (flag_s),
      .dmem_we_o    (dmem_we_o),
      .dmem_addr_o  (dmem_addr_o),
      .dmem_w_dt_o  (dmem_w_dt_o),
      .wb_we_o      (wb_we),
      .wb_rd_o      (wb_rd),
      .wb_load_o    (wb_load),
      .wb_alu_dt_o  (wb_alu_dt)
   );

   core_reg_bank u_reg_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .restart_i   (restart_i),
      .rs0_i       (rs0),
      .rs1_i       (rs1),
      .wb_we_i     (wb_we),
      .wb_rd_i     (wb_rd),
      .wb_load_i   (wb_load),
      .wb_alu_dt_i (wb_alu_dt),
      .dmem_r_dt_i (dmem_r_dt_i),
      .rs0_dt_o    (rs0_dt),
      .rs1_dt_o    (rs1_dt)
   );

endmodule

//--- src/core_execute.sv
`timescale 1ns/1ps

module core_execute import core_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       restart_i,
   input  logic       run_i,
   input  data_t      op_a_i,
   input  data_t      op_b_i,
   input  data_t      st_dt_i,
   input  alu_op_e    alu_op_i,
   input  reg_addr_t  rd_i,
   input  logic       rd_we_i,
   input  logic       load_i,
   input  logic       store_i,
   input  logic       flag_we_i,
   output reg_addr_t  x1_rd_o,
   output logic       x1_rd_we_o,
   output logic       x1_flag_we_o,
   output logic       flag_z_o,
   output logic       flag_s_o,
   output logic       dmem_we_o,
   output dmem_addr_t dmem_addr_o,
   output data_t      dmem_w_dt_o,
   output logic       wb_we_o,
   output reg_addr_t  wb_rd_o,
   output logic       wb_load_o,
   output data_t      wb_alu_dt_o
);

   data_t      x1_op_a, x1_op_b, x1_st_dt;
   alu_op_e    x1_alu_op;
   reg_addr_t  x1_rd;
   logic       x1_rd_we, x1_load, x1_store, x1_flag_we;
   data_t      alu_res;
   data_t      addr_sum;
   dmem_addr_t mem_addr;
   logic       wb_we, wb_load;
   reg_addr_t  wb_rd;
   data_t      wb_alu_dt;
   dmem_addr_t wb_addr;
   logic       flag_z, flag_s;

   //////////////////////////////////////////////////////////////////////
   // Stage registers

   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         x1_rd_we   <= 1'b0;
         x1_load    <= 1'b0;
         x1_store   <= 1'b0;
         x1_flag_we <= 1'b0;
         wb_we      <= 1'b0;
         wb_load    <= 1'b0;
         flag_z     <= 1'b0;
         flag_s     <= 1'b0;
      end else if (run_i) begin
         x1_rd_we   <= rd_we_i;
         x1_load    <= load_i;
         x1_store   <= store_i;
         x1_flag_we <= flag_we_i;
         wb_we      <= x1_rd_we;
         wb_load    <= x1_load;
         if (x1_flag_we) begin
            flag_z <= (alu_res == '0);
            flag_s <= alu_res[$bits(data_t)-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (run_i) begin
         x1_op_a   <= op_a_i;
         x1_op_b   <= op_b_i;
         x1_st_dt  <= st_dt_i;
         x1_alu_op <= alu_op_i;
         x1_rd     <= rd_i;
         wb_rd     <= x1_rd;
         wb_alu_dt <= alu_res;
         wb_addr   <= mem_addr;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ALU and memory address

   always_comb begin
      unique case (x1_alu_op)
         ALU_ADD:  alu_res = x1_op_a + x1_op_b;
         ALU_SUB:  alu_res = x1_op_a - x1_op_b;
         ALU_AND:  alu_res = x1_op_a & x1_op_b;
         ALU_OR:   alu_res = x1_op_a | x1_op_b;
         ALU_XOR:  alu_res = x1_op_a ^ x1_op_b;
         ALU_SHL:  alu_res = x1_op_a << x1_op_b[4:0];
         ALU_SHR:  alu_res = x1_op_a >> x1_op_b[4:0];
         ALU_PASS: alu_res = x1_op_b;
      endcase
   end

   assign addr_sum = x1_op_a + x1_op_b;   // Operand B holds the immediate here
   assign mem_addr = addr_sum[$bits(dmem_addr_t)-1:0];

   // Halted, memory keeps reading the load address of the write-back slot
   assign dmem_addr_o = run_i ? mem_addr : wb_addr;
   assign dmem_we_o   = x1_store & run_i;
   assign dmem_w_dt_o = x1_st_dt;

   assign x1_rd_o      = x1_rd;
   assign x1_rd_we_o   = x1_rd_we;
   assign x1_flag_we_o = x1_flag_we;
   assign flag_z_o     = flag_z;
   assign flag_s_o     = flag_s;

   assign wb_we_o     = wb_we & run_i;
   assign wb_rd_o     = wb_rd;
   assign wb_load_o   = wb_load;
   assign wb_alu_dt_o = wb_alu_dt;

   // Decode issues one instruction type per slot
   assert property (@(posedge clk_i) disable iff (!rst_ni) !(x1_load && x1_store));

endmodule

//--- src/core_reg_bank.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_reg_bank import core_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_ni,
   input  logic      restart_i,
   input  reg_addr_t rs0_i,
   input  reg_addr_t rs1_i,
   input  logic      wb_we_i,
   input  reg_addr_t wb_rd_i,
   input  logic      wb_load_i,
   input  data_t     wb_alu_dt_i,
   input  data_t     dmem_r_dt_i,
   output data_t     rs0_dt_o,
   output data_t     rs1_dt_o
);

   data_t regs [`CORE_REG_N];
   data_t w_dt;
   logic  w_en;

   // Register 0 is hardwired, a same-cycle write is passed straight through
   function automatic data_t read_port(reg_addr_t addr);
      if (addr == '0) begin
         return '0;
      end
      if (w_en && (wb_rd_i == addr)) begin
         return w_dt;
      end
      return regs[addr];
   endfunction

   assign w_dt = wb_load_i ? dmem_r_dt_i : wb_alu_dt_i;
   assign w_en = wb_we_i && (wb_rd_i != '0);

   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         for (int i = 0; i < `CORE_REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (w_en) begin
         regs[wb_rd_i] <= w_dt;
      end
   end

   always_comb begin
      rs0_dt_o = read_port(rs0_i);
      rs1_dt_o = read_port(rs1_i);
   end

endmodule

//--- src/core_decode.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_decode import core_pkg::*; (
   input  instr_t     instr_i,
   input  data_t      rs0_dt_i,
   input  data_t      rs1_dt_i,
   input  reg_addr_t  x1_rd_i,
   input  logic       x1_rd_we_i,
   input  logic       x1_flag_we_i,
   input  logic       flag_z_i,
   input  logic       flag_s_i,
   input  logic       flag_i,
   output reg_addr_t  rs0_o,
   output reg_addr_t  rs1_o,
   output logic       stall_o,
   output logic       branch_o,
   output pmem_addr_t target_o,
   output data_t      op_a_o,
   output data_t      op_b_o,
   output data_t      st_dt_o,
   output alu_op_e    alu_op_o,
   output reg_addr_t  rd_o,
   output logic       rd_we_o,
   output logic       load_o,
   output logic       store_o,
   output logic       flag_we_o
);

   header_e header;
   cond_e   cond;
   logic    imm_sel;
   logic    flag_wr;
   imm_t    imm;
   data_t   imm_ext;
   logic    type_wr, type_ld, type_st, type_br;
   logic    rs0_used, rs1_used;
   logic    reg_hazard, flag_hazard;
   logic    cond_ok, exec_ok;

   //////////////////////////////////////////////////////////////////////
   // Field split

   assign header   = header_e'(instr_i[`CORE_HDR_HI:`CORE_HDR_LO]);
   assign cond     = cond_e'(instr_i[`CORE_COND_HI:`CORE_COND_LO]);
   assign alu_op_o = alu_op_e'(instr_i[`CORE_ALU_HI:`CORE_ALU_LO]);
   assign imm_sel  = instr_i[`CORE_IMM_SEL_BIT];
   assign flag_wr  = instr_i[`CORE_FLAG_WE_BIT];
   assign rd_o     = instr_i[`CORE_RD_HI:`CORE_RD_LO];
   assign rs0_o    = instr_i[`CORE_RS0_HI:`CORE_RS0_LO];
   assign rs1_o    = instr_i[`CORE_RS1_HI:`CORE_RS1_LO];
   assign imm      = instr_i[`CORE_IMM_HI:`CORE_IMM_LO];
   assign imm_ext  = {{(`CORE_DATA_W - `CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm};
   assign target_o = imm[`CORE_PMEM_AW-1:0];

   // Loads and stores always take the immediate as address offset
   assign op_a_o  = rs0_dt_i;
   assign op_b_o  = (imm_sel || type_ld || type_st) ? imm_ext : rs1_dt_i;
   assign st_dt_o = rs1_dt_i;

   //////////////////////////////////////////////////////////////////////
   // Condition, hazard and strobes

   always_comb begin
      type_wr = (header == HDR_REG_WR);
      type_ld = (header == HDR_REG_LD);
      type_st = (header == HDR_MEM_WR);
      type_br = (header == HDR_BRANCH);

      unique case (cond)
         COND_ALWAYS: cond_ok = 1'b1;
         COND_Z:      cond_ok = flag_z_i;
         COND_S:      cond_ok = flag_s_i;
         COND_NZ:     cond_ok = ~flag_z_i;
         COND_NS:     cond_ok = ~flag_s_i;
         COND_FLAG:   cond_ok = flag_i;
         COND_NFLAG:  cond_ok = ~flag_i;
         COND_NEVER:  cond_ok = 1'b0;
      endcase

      rs0_used = type_wr | type_ld | type_st;
      rs1_used = (type_wr & ~imm_sel) | type_st;

      // Result in execute is one cycle from the bank write-through
      reg_hazard = x1_rd_we_i && (x1_rd_i != '0)
                   && ((rs0_used && (rs0_o == x1_rd_i)) || (rs1_used && (rs1_o == x1_rd_i)));
      flag_hazard = x1_flag_we_i && (type_wr || type_ld || type_st || type_br)
                    && (cond inside {COND_Z, COND_S, COND_NZ, COND_NS});
      stall_o = reg_hazard | flag_hazard;

      exec_ok   = cond_ok & ~stall_o;   // Stalled slot leaves as a bubble
      rd_we_o   = exec_ok & (type_wr | type_ld);
      load_o    = exec_ok & type_ld;
      store_o   = exec_ok & type_st;
      flag_we_o = exec_ok & type_wr & flag_wr;  // Only ALU writes set flags
      branch_o  = exec_ok & type_br;

      // Fetch would load a target whose condition was not yet valid
      assert (!(branch_o && x1_flag_we_i
                && (cond inside {COND_Z, COND_S, COND_NZ, COND_NS})));
   end

endmodule

//--- src/core_fetch.sv
`timescale 1ns/1ps

module core_fetch import core_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       restart_i,
   input  logic       run_i,
   input  logic       stall_i,
   input  logic       branch_i,
   input  pmem_addr_t target_i,
   input  instr_t     pmem_dt_i,
   output pmem_addr_t pmem_addr_o,
   output logic       pmem_en_o,
   output instr_t     instr_o
);

   pmem_addr_t pc;
   instr_t     instr;
   logic       flush;     // Drop the next captured slot
   logic       fetch_en;

   assign fetch_en = run_i & ~stall_i;

   //////////////////////////////////////////////////////////////////////
   // Program counter and instruction register

   // A stale memory word follows reset, so the first slot is dropped too
   always_ff @(posedge clk_i) begin
      if (!rst_ni || restart_i) begin
         pc    <= '0;
         instr <= '0;
         flush <= 1'b1;
      end else if (fetch_en) begin
         if (branch_i) begin
            pc <= target_i;
         end else begin
            pc <= pc + 1'b1;
         end
         if (flush || branch_i) begin
            instr <= '0;         // NOP into decode
         end else begin
            instr <= pmem_dt_i;
         end
         flush <= branch_i;      // Word already in flight behind the branch
      end
   end

   assign pmem_addr_o = pc;
   assign pmem_en_o   = fetch_en;   // Memory holds its output while low
   assign instr_o     = instr;

   // With the read strobe low the memory output is reused, so the address must not move
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!pmem_en_o && !branch_i && !restart_i) |=> $stable(pmem_addr_o));

endmodule

//--- src/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

   typedef logic [`CORE_DATA_W-1:0]  data_t;
   typedef logic [`CORE_PMEM_AW-1:0] pmem_addr_t;
   typedef logic [`CORE_DMEM_AW-1:0] dmem_addr_t;
   typedef logic [`CORE_REG_AW-1:0]  reg_addr_t;
   typedef logic [`CORE_INSTR_W-1:0] instr_t;
   typedef logic [`CORE_IMM_W-1:0]   imm_t;

   // Instruction type, codes 5 to 7 behave as NOP
   typedef enum logic [2:0] {
      HDR_NOP    = 3'd0,
      HDR_REG_WR = 3'd1,  // rd <= ALU result
      HDR_REG_LD = 3'd2,  // rd <= dmem[rs0 + imm]
      HDR_MEM_WR = 3'd3,  // dmem[rs0 + imm] <= rs1
      HDR_BRANCH = 3'd4   // pc <= imm
   } header_e;

   typedef enum logic [2:0] {
      COND_ALWAYS = 3'd0,
      COND_Z      = 3'd1,
      COND_S      = 3'd2,
      COND_NZ     = 3'd3,
      COND_NS     = 3'd4,
      COND_FLAG   = 3'd5,  // External flag high
      COND_NFLAG  = 3'd6,  // External flag low
      COND_NEVER  = 3'd7
   } cond_e;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS
   } alu_op_e;

endpackage

//--- src/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and memory widths
`define CORE_DATA_W      32
`define CORE_PMEM_AW     8
`define CORE_DMEM_AW     8
`define CORE_REG_AW      4
`define CORE_REG_N       (1 << `CORE_REG_AW)
`define CORE_INSTR_W     40

// Instruction word fields, bit 28 is spare
`define CORE_HDR_HI      39
`define CORE_HDR_LO      37
`define CORE_COND_HI     36
`define CORE_COND_LO     34
`define CORE_ALU_HI      33
`define CORE_ALU_LO      31
`define CORE_IMM_SEL_BIT 30
`define CORE_FLAG_WE_BIT 29
`define CORE_RD_HI       27
`define CORE_RD_LO       24
`define CORE_RS0_HI      23
`define CORE_RS0_LO      20
`define CORE_RS1_HI      19
`define CORE_RS1_LO      16
`define CORE_IMM_HI      15
`define CORE_IMM_LO      0
`define CORE_IMM_W       (`CORE_IMM_HI - `CORE_IMM_LO + 1)

`endif
